// File: src/tia_reg_pkg.sv
////////////////////////////////////////////////////////////
// TIA write register map
// Write addresses and the two views of a written data byte
////////////////////////////////////////////////////////////
`default_nettype none

package tia_reg_pkg;

	// Write addresses handled by this adaptor
	typedef enum logic [5:0] {
		VSYNC  = 6'h00, // Vertical sync in D1
		VBLANK = 6'h01, // Vertical blank in D1
		WSYNC  = 6'h02, // Strobe to halt CPU until blank
		RSYNC  = 6'h03, // Strobe to restart the line
		COLUP0 = 6'h06, // Player 0 colour, used by score mode
		COLUP1 = 6'h07, // Player 1 colour, used by score mode
		COLUPF = 6'h08,
		COLUBK = 6'h09,
		CTRLPF = 6'h0a, // Reflect and score bits
		PF0    = 6'h0d, // Upper nibble only
		PF1    = 6'h0e,
		PF2    = 6'h0f
	} tia_addr_e;

	// Bit positions inside the VSYNC and VBLANK bytes
	localparam int vsync_bit  = 1;
	localparam int vblank_bit = 1;

	// One data byte seen as colour-lum or as CTRLPF
	typedef union packed {
		struct packed {
			logic [3:0] hue;
			logic [2:0] lum;
			logic       unused;    // D0 ignored
		} color;
		struct packed {
			logic [1:0] unused;    // D7-6
			logic [1:0] ball_size; // D5-4
			logic       spare;     // D3
			logic       pfp;       // Playfield priority
			logic       score;     // Score colouring
			logic       reflect;   // Mirror right half
		} ctrl;
	} tia_data_u;

endpackage

`default_nettype wire

// File: src/tia_video_pkg.sv
////////////////////////////////////////////////////////////
// TIA video definitions
// Line timing defaults, colour word and column count types
////////////////////////////////////////////////////////////
`default_nettype none

package tia_video_pkg;

	// Hue in bits 6..3, luminance in bits 2..0
	typedef logic [6:0] color_t;

	// Colour clock position on the line
	typedef logic [7:0] column_t;

	////////////////////////////////////////////////////////////
	// Default line timing in colour clocks
	////////////////////////////////////////////////////////////
	localparam int H_TOTAL_DEF      = 228; // Full line
	localparam int HBLANK_START_DEF = 160; // Visible area ends here
	localparam int HSYNC_START_DEF  = 186;
	localparam int HSYNC_WIDTH_DEF  = 16;

	// Playfield geometry
	localparam int PF_PIXEL_WIDTH = 4;  // Colour clocks per bit
	localparam int PF_BITS        = 20; // Bits per screen half

endpackage

`default_nettype wire

// File: src/tia_regs.sv
////////////////////////////////////////////////////////////
// TIA register control
// Write decoder, stored control bits and WSYNC ready latch
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module tia_regs #(
	parameter int HBLANK_START = tia_video_pkg::HBLANK_START_DEF
) (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     wr,
	input  wire tia_reg_pkg::tia_addr_e addr,
	input  wire tia_reg_pkg::tia_data_u d_in,
	input  wire tia_video_pkg::column_t column,
	output logic [2:0]              pf_we,    // PF0, PF1, PF2
	output logic [3:0]              color_we, // COLUP0, COLUP1, COLUPF, COLUBK
	output logic                    rsync,
	output logic                    mirror,
	output logic                    score,
	output logic                    vsync,
	output logic                    vblank,
	output logic                    rdy
);
	import tia_reg_pkg::*;
	import tia_video_pkg::*;

	logic wsync_wr;
	logic vsync_wr;
	logic vblank_wr;
	logic ctrlpf_wr;
	logic wait_q;     // CPU held by WSYNC
	logic at_start_q; // Column was at blank start last cycle
	logic at_start;   // First cycle at blank start

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////
	always_comb begin
		pf_we     = '0;
		color_we  = '0;
		rsync     = 1'b0;
		wsync_wr  = 1'b0;
		vsync_wr  = 1'b0;
		vblank_wr = 1'b0;
		ctrlpf_wr = 1'b0;
		if (wr) begin
			case (addr)
				VSYNC:   vsync_wr    = 1'b1;
				VBLANK:  vblank_wr   = 1'b1;
				WSYNC:   wsync_wr    = 1'b1;
				RSYNC:   rsync       = 1'b1; // Line restarts next edge
				COLUP0:  color_we[0] = 1'b1;
				COLUP1:  color_we[1] = 1'b1;
				COLUPF:  color_we[2] = 1'b1;
				COLUBK:  color_we[3] = 1'b1;
				CTRLPF:  ctrlpf_wr   = 1'b1;
				PF0:     pf_we[0]    = 1'b1;
				PF1:     pf_we[1]    = 1'b1;
				PF2:     pf_we[2]    = 1'b1;
				default: ;                       // Unused address
			endcase
		end
	end

	// Control bits kept here
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync  <= 1'b0;
			vblank <= 1'b0;
			mirror <= 1'b0;
			score  <= 1'b0;
		end else begin
			if (vsync_wr)
				vsync <= d_in[vsync_bit];
			if (vblank_wr)
				vblank <= d_in[vblank_bit];
			if (ctrlpf_wr) begin
				mirror <= d_in.ctrl.reflect;
				score  <= d_in.ctrl.score;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// WSYNC ready latch
	////////////////////////////////////////////////////////////
	// Column may sit at blank start for several clocks with ce low
	assign at_start = (column == column_t'(HBLANK_START)) && !at_start_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_q     <= 1'b0;
			at_start_q <= 1'b0;
		end else begin
			at_start_q <= (column == column_t'(HBLANK_START));
			if (wsync_wr)
				wait_q <= 1'b1;       // Halt from next cycle on
			else if (at_start)
				wait_q <= 1'b0;
		end
	end

	assign rdy = !wait_q || at_start; // Released as the column lands on blank start

endmodule

`default_nettype wire

// File: src/horiz_gen.sv
////////////////////////////////////////////////////////////
// Horizontal timing
// Colour clock line counter with blank and sync decode
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module horiz_gen #(
	parameter int H_TOTAL      = tia_video_pkg::H_TOTAL_DEF,
	parameter int HBLANK_START = tia_video_pkg::HBLANK_START_DEF,
	parameter int HSYNC_START  = tia_video_pkg::HSYNC_START_DEF,
	parameter int HSYNC_WIDTH  = tia_video_pkg::HSYNC_WIDTH_DEF
) (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    ce,    // Colour clock enable
	input  wire                    rsync, // Restart line
	output tia_video_pkg::column_t column,
	output logic                   hblank,
	output logic                   hsync
);
	import tia_video_pkg::*;

	localparam column_t LAST_COL   = column_t'(H_TOTAL - 1);
	localparam column_t BLANK_FROM = column_t'(HBLANK_START);
	localparam column_t SYNC_FROM  = column_t'(HSYNC_START);
	localparam column_t SYNC_TO    = column_t'(HSYNC_START + HSYNC_WIDTH); // First column past sync

	// Line counter
	always_ff @(posedge clk) begin
		if (reset || rsync) begin
			column <= '0;
		end else if (ce) begin
			if (column == LAST_COL)
				column <= '0;          // Wrap at end of line
			else
				column <= column + 1'b1;
		end
	end

	// Decoded straight from the count
	assign hblank = (column >= BLANK_FROM);
	assign hsync  = (column >= SYNC_FROM) && (column < SYNC_TO);

endmodule

`default_nettype wire

// File: src/playfield.sv
////////////////////////////////////////////////////////////
// Playfield
// 20-bit playfield register and pixel pick per column
// Right half repeats or mirrors the left half
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module playfield (
	input  wire                         clk,
	input  wire                         reset,
	input  wire [2:0]                   pf_we,  // PF0, PF1, PF2
	input  wire [7:0]                   d_in,
	input  wire tia_video_pkg::column_t column,
	input  wire                         hblank,
	input  wire                         mirror, // Right half reversed
	output logic                        pf
);
	import tia_video_pkg::*;

	localparam int IDX_W = $clog2(PF_BITS);

	logic [PF_BITS-1:0] pf_bits;
	column_t            k;       // Playfield bit slot on the line
	logic [IDX_W-1:0]   pix_idx;

	////////////////////////////////////////////////////////////
	// Register writes
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			pf_bits <= '0;
		end else begin
			if (pf_we[0])
				pf_bits[3:0] <= d_in[7:4];  // PF0 keeps its upper nibble
			if (pf_we[1])
				pf_bits[11:4] <= d_in;
			if (pf_we[2])
				pf_bits[19:12] <= d_in;
		end
	end

	////////////////////////////////////////////////////////////
	// Pixel selection
	////////////////////////////////////////////////////////////
	assign k = column / column_t'(PF_PIXEL_WIDTH);

	always_comb begin
		pix_idx = '0;
		if (k < column_t'(PF_BITS)) begin
			pix_idx = IDX_W'(k);                                  // Left half
		end else if (k < column_t'(2 * PF_BITS)) begin
			if (mirror)
				pix_idx = IDX_W'(column_t'(2 * PF_BITS - 1) - k); // Reversed copy
			else
				pix_idx = IDX_W'(k - column_t'(PF_BITS));         // Straight repeat
		end
	end

	// Nothing shown during blank
	assign pf = !hblank && pf_bits[pix_idx];

endmodule

`default_nettype wire

// File: src/color_output.sv
////////////////////////////////////////////////////////////
// Colour output
// Colour registers and final colour-lum choice per pixel
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module color_output #(
	parameter int HBLANK_START = tia_video_pkg::HBLANK_START_DEF
) (
	input  wire                         clk,
	input  wire                         reset,
	input  wire [3:0]                   color_we,
	input  wire tia_reg_pkg::tia_data_u d_in,
	input  wire tia_video_pkg::column_t column,
	input  wire                         hblank,
	input  wire                         vblank,
	input  wire                         pf,     // Playfield pixel
	input  wire                         score,  // Playfield takes player colours
	output logic [3:0]                  col,
	output logic [2:0]                  lum
);
	import tia_video_pkg::*;

	// Slots in color_regs, same order as color_we
	localparam int SLOT_P0 = 0;
	localparam int SLOT_P1 = 1;
	localparam int SLOT_PF = 2;
	localparam int SLOT_BK = 3;

	localparam column_t HALF_COL = column_t'(HBLANK_START / 2); // Start of right half

	color_t color_regs [4];
	color_t pix_color;
	logic   right_half;

	// Colour register writes
	always_ff @(posedge clk) begin
		if (reset) begin
			color_regs <= '{default: '0};
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (color_we[i])
					color_regs[i] <= {d_in.color.hue, d_in.color.lum};
			end
		end
	end

	assign right_half = (column >= HALF_COL);

	////////////////////////////////////////////////////////////
	// Pixel colour
	////////////////////////////////////////////////////////////
	always_comb begin
		if (hblank || vblank)
			pix_color = '0;                                       // Black in blank
		else if (pf && score)
			pix_color = right_half ? color_regs[SLOT_P1] : color_regs[SLOT_P0];
		else if (pf)
			pix_color = color_regs[SLOT_PF];
		else
			pix_color = color_regs[SLOT_BK];                      // Background
	end

	assign col = pix_color[6:3];
	assign lum = pix_color[2:0];

endmodule

`default_nettype wire

// File: src/tia_top.sv
////////////////////////////////////////////////////////////
// TIA video top
// Register control, line timing, playfield and colour out
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module tia_top #(
	parameter int H_TOTAL      = tia_video_pkg::H_TOTAL_DEF,
	parameter int HBLANK_START = tia_video_pkg::HBLANK_START_DEF,
	parameter int HSYNC_START  = tia_video_pkg::HSYNC_START_DEF,
	parameter int HSYNC_WIDTH  = tia_video_pkg::HSYNC_WIDTH_DEF
) (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         ce,     // Colour clock enable
	input  wire                         wr,     // Write taken on every clk
	input  wire tia_reg_pkg::tia_addr_e addr,
	input  wire tia_reg_pkg::tia_data_u d_in,
	output wire                         rdy,    // CPU ready, low during WSYNC
	output wire [3:0]                   col,
	output wire [2:0]                   lum,
	output wire                         hsync,
	output wire                         hblank,
	output wire                         vsync,
	output wire                         vblank
);
	import tia_video_pkg::*;

	wire [2:0] pf_we;
	wire [3:0] color_we;
	wire       rsync;
	wire       mirror;
	wire       score;
	wire       pf;
	wire column_t column;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////
	tia_regs #(
		.HBLANK_START (HBLANK_START)
	) u_regs (
		.clk      (clk),
		.reset    (reset),
		.wr       (wr),
		.addr     (addr),
		.d_in     (d_in),
		.column   (column),
		.pf_we    (pf_we),
		.color_we (color_we),
		.rsync    (rsync),
		.mirror   (mirror),
		.score    (score),
		.vsync    (vsync),
		.vblank   (vblank),
		.rdy      (rdy)
	);

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////
	horiz_gen #(
		.H_TOTAL      (H_TOTAL),
		.HBLANK_START (HBLANK_START),
		.HSYNC_START  (HSYNC_START),
		.HSYNC_WIDTH  (HSYNC_WIDTH)
	) u_horiz (
		.clk    (clk),
		.reset  (reset),
		.ce     (ce),
		.rsync  (rsync),
		.column (column),
		.hblank (hblank),
		.hsync  (hsync)
	);

	playfield u_pf (
		.clk    (clk),
		.reset  (reset),
		.pf_we  (pf_we),
		.d_in   (d_in),      // Raw byte
		.column (column),
		.hblank (hblank),
		.mirror (mirror),
		.pf     (pf)
	);

	color_output #(
		.HBLANK_START (HBLANK_START)
	) u_color (
		.clk      (clk),
		.reset    (reset),
		.color_we (color_we),
		.d_in     (d_in),
		.column   (column),
		.hblank   (hblank),
		.vblank   (vblank),
		.pf       (pf),
		.score    (score),
		.col      (col),
		.lum      (lum)
	);

endmodule

`default_nettype wire

// File: tb/tb_util.svh
////////////////////////////////////////////////////////////
// TIA testbench helpers
// LFSR source, reference video model and compare tasks
////////////////////////////////////////////////////////////
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	logic fb;
	fb = s[15] ^ s[13] ^ s[12] ^ s[10];
	return {s[14:0], fb};
endfunction

// Takes n bits, one LFSR step per bit
function automatic logic [7:0] rand_bits(input int n);
	logic [7:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		r          = {r[6:0], lfsr_state[0]}; // New feedback bit
	end
	return r;
endfunction

////////////////////////////////////////////////////////////
// Expected {colour, hblank, hsync} for one column
////////////////////////////////////////////////////////////
function automatic logic [8:0] ref_video(input column_t c, input logic [19:0] pf_bits,
		input logic mirror, input logic score, input logic vblank, input color_t [3:0] colors);
	logic   hb;
	logic   hs;
	logic   pix;
	int     k;
	color_t pc;
	hb  = (c >= BLANK_COL);
	hs  = (c >= SYNC_COL) && (c < SYNC_COL + SYNC_LEN);
	k   = c / PF_PIX;                               // Playfield slot
	pix = 1'b0;
	if (k < 20)
		pix = pf_bits[k];
	else if (k < 40)
		pix = mirror ? pf_bits[39 - k] : pf_bits[k - 20];
	if (hb || vblank)
		pc = '0;                                    // Black in any blank
	else if (pix && score)
		pc = (c >= HALF_COL) ? colors[1] : colors[0];
	else if (pix)
		pc = colors[2];
	else
		pc = colors[3];
	return {pc, hb, hs};
endfunction

// Colour word compare
task automatic check_color(input string name, input color_t got, input color_t exp_v);
	checks++;
	if (got !== exp_v) begin
		errors++;
		$display("ERROR t=%0t %s got %02h expected %02h", $time, name, got, exp_v);
	end
endtask

// Single bit compare
task automatic check_bit(input string name, input logic got, input logic exp_v);
	checks++;
	if (got !== exp_v) begin
		errors++;
		$display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp_v);
	end
endtask

`endif

// File: tb/tb_tia.sv
////////////////////////////////////////////////////////////
// TIA video testbench
// Random register writes against a cycle model of the line
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module tb_tia;
	import tia_reg_pkg::*;
	import tia_video_pkg::*;

	localparam int LINE_LEN     = 228;
	localparam int BLANK_COL    = 160;
	localparam int SYNC_COL     = 186;
	localparam int SYNC_LEN     = 16;
	localparam int HALF_COL     = 80;  // Score mode switches to P1 here
	localparam int PF_PIX       = 4;
	localparam int LINE_TIMEOUT = 2 * LINE_LEN; // Cycles with room for ce gaps

	logic       clk;
	logic       reset;
	logic       ce;
	logic       wr;
	tia_addr_e  addr;
	tia_data_u  d_in;
	logic       rdy;
	logic [3:0] col;
	logic [2:0] lum;
	logic       hsync;
	logic       hblank;
	logic       vsync;
	logic       vblank;

	int          errors        = 0;
	int          checks        = 0;
	int          lines_checked = 0; // Full lines measured
	int          line_starts   = 0; // Every hsync rise
	logic        timed_out     = 1'b0;
	logic        ce_gaps       = 1'b0;
	logic [15:0] lfsr_state;

	// Cycle model of the DUT state
	column_t         m_column;
	logic [19:0]     m_pf;
	color_t [3:0]    m_colors; // P0, P1, PF, BK
	logic            m_mirror;
	logic            m_score;
	logic            m_vsync;
	logic            m_vblank;
	logic            m_wait;   // CPU held by WSYNC
	logic            line_valid;
	logic            hsync_prev;
	int              ce_count;

	`include "tb_util.svh"

	tia_top #(
		.H_TOTAL      (LINE_LEN),
		.HBLANK_START (BLANK_COL),
		.HSYNC_START  (SYNC_COL),
		.HSYNC_WIDTH  (SYNC_LEN)
	) uut (
		.clk    (clk),
		.reset  (reset),
		.ce     (ce),
		.wr     (wr),
		.addr   (addr),
		.d_in   (d_in),
		.rdy    (rdy),
		.col    (col),
		.lum    (lum),
		.hsync  (hsync),
		.hblank (hblank),
		.vsync  (vsync),
		.vblank (vblank)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Compare process on the falling edge
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin : compare_outputs
		logic [8:0] exp_v;
		column_t    nc;
		color_t     cval;
		if (reset !== 1'b0) begin
			m_column   = '0;
			m_pf       = '0;
			m_colors   = '0;
			m_mirror   = 1'b0;
			m_score    = 1'b0;
			m_vsync    = 1'b0;
			m_vblank   = 1'b0;
			m_wait     = 1'b0;
			line_valid = 1'b0;
			hsync_prev = 1'b0;
			ce_count   = 0;
		end else begin
			exp_v = ref_video(m_column, m_pf, m_mirror, m_score, m_vblank, m_colors);
			check_color("col_lum", {col, lum}, exp_v[8:2]);
			check_bit("hblank", hblank, exp_v[1]);
			check_bit("hsync", hsync, exp_v[0]);
			check_bit("rdy", rdy, !m_wait);
			check_bit("vsync", vsync, m_vsync);
			check_bit("vblank", vblank, m_vblank);

			// Line length between hsync rises
			if (hsync && !hsync_prev) begin
				line_starts++;
				if (line_valid) begin
					lines_checked++;
					if (ce_count != LINE_LEN) begin
						errors++;
						$display("Line lasted %0d ce pulses instead of %0d at t=%0t",
							ce_count, LINE_LEN, $time);
					end
				end
				line_valid = 1'b1;
				ce_count   = 0;
			end
			hsync_prev = hsync;
			if (ce)
				ce_count++;

			// Advance the model by what the next edge samples
			if (wr && addr == RSYNC) begin
				nc         = '0;
				line_valid = 1'b0; // Restarted line is not measured
			end else if (ce) begin
				nc = (m_column == LINE_LEN - 1) ? column_t'(0) : m_column + 1'b1;
			end else begin
				nc = m_column;
			end
			if (nc == BLANK_COL && m_column != BLANK_COL)
				m_wait = 1'b0;     // Released as blank starts
			else if (wr && addr == WSYNC)
				m_wait = 1'b1;

			cval = {d_in.color.hue, d_in.color.lum};
			if (wr) begin
				case (addr)
					VSYNC:   m_vsync = d_in[vsync_bit];
					VBLANK:  m_vblank = d_in[vblank_bit];
					CTRLPF: begin
						m_mirror = d_in.ctrl.reflect;
						m_score  = d_in.ctrl.score;
					end
					COLUP0:  m_colors[0] = cval;
					COLUP1:  m_colors[1] = cval;
					COLUPF:  m_colors[2] = cval;
					COLUBK:  m_colors[3] = cval;
					PF0:     m_pf[3:0] = d_in[7:4];
					PF1:     m_pf[11:4] = d_in;
					PF2:     m_pf[19:12] = d_in;
					default: ;
				endcase
			end
			m_column = nc;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////
	function automatic logic next_ce();
		return ce_gaps ? (rand_bits(2) != 8'h00) : 1'b1; // Low about one in four
	endfunction

	task automatic step_clk;
		@(posedge clk);
		wr <= 1'b0;
		ce <= next_ce();
	endtask

	task automatic write_reg(input tia_addr_e a, input tia_data_u d);
		@(posedge clk);
		wr   <= 1'b1;
		addr <= a;
		d_in <= d;
		ce   <= next_ce();
	endtask

	task automatic wait_line_starts(input int n);
		int target;
		int cnt;
		target = line_starts + n;
		cnt    = 0;
		while (line_starts < target && cnt < n * LINE_TIMEOUT) begin
			step_clk();
			cnt++;
		end
		if (line_starts < target) begin
			errors++;
			timed_out = 1'b1;
			$display("Timed out waiting for %0d new lines", n);
		end
	endtask

	task automatic wait_rdy_high;
		int   cnt;
		logic seen;
		cnt  = 0;
		seen = 1'b0;
		while (!seen && cnt < LINE_TIMEOUT) begin
			step_clk();
			@(negedge clk);
			seen = rdy;
			cnt++;
		end
		if (!seen) begin
			errors++;
			timed_out = 1'b1;
			$display("Timed out waiting for rdy to return high after WSYNC");
		end
	endtask

	task automatic wait_hblank_low;
		int   cnt;
		logic seen;
		cnt  = 0;
		seen = 1'b0;
		while (!seen && cnt < LINE_TIMEOUT) begin
			step_clk();
			@(negedge clk);
			seen = !hblank;
			cnt++;
		end
		if (!seen) begin
			errors++;
			timed_out = 1'b1;
			$display("Timed out waiting for the visible part of the line");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	task automatic run_tests;
		tia_data_u d;
		tia_data_u d2;
		// Reset values
		@(negedge clk);
		check_bit("rdy after reset", rdy, 1'b1);
		check_bit("hsync after reset", hsync, 1'b0);
		check_bit("vsync after reset", vsync, 1'b0);
		check_bit("vblank after reset", vblank, 1'b0);
		check_color("col_lum after reset", {col, lum}, '0);

		// Lines with ce gaps and a restart mid-line
		ce_gaps = 1'b1;
		wait_line_starts(3);
		if (timed_out) return;
		repeat (37) step_clk();
		write_reg(RSYNC, '0);
		step_clk();
		wait_line_starts(2);
		if (timed_out) return;

		// Playfield repeat and mirror over every column with ce held high
		ce_gaps = 1'b0;
		for (int round = 0; round < 4; round++) begin
			write_reg(PF0, rand_bits(8));
			write_reg(PF1, rand_bits(8));
			write_reg(PF2, rand_bits(8));
			d  = rand_bits(8);
			d2 = rand_bits(8);
			if (d2[7:1] == d[7:1])
				d2[7] = ~d2[7];        // Keep PF and BK apart
			write_reg(COLUPF, d);
			write_reg(COLUBK, d2);
			d              = '0;
			d.ctrl.reflect = round[0];
			write_reg(CTRLPF, d);
			step_clk();
			wait_line_starts(2);
			if (timed_out) return;
		end

		// Score colouring with a random then a full playfield
		ce_gaps = 1'b1;
		d  = rand_bits(8);
		d2 = rand_bits(8);
		if (d2[7:1] == d[7:1])
			d2[6] = ~d2[6];
		write_reg(COLUP0, d);
		write_reg(COLUP1, d2);
		write_reg(PF1, rand_bits(8));
		d            = '0;
		d.ctrl.score = 1'b1;
		write_reg(CTRLPF, d);
		step_clk();
		wait_line_starts(2);
		if (timed_out) return;
		write_reg(PF0, 8'hf0);
		write_reg(PF1, 8'hff);
		write_reg(PF2, 8'hff);
		d.ctrl.reflect = 1'b1;
		write_reg(CTRLPF, d);
		step_clk();
		wait_line_starts(2);
		if (timed_out) return;

		// WSYNC halt and release at blank start
		for (int round = 0; round < 3; round++) begin
			wait_hblank_low();
			if (timed_out) return;
			write_reg(WSYNC, '0);
			step_clk();
			@(negedge clk);
			check_bit("rdy after WSYNC", rdy, 1'b0);
			wait_rdy_high();
			if (timed_out) return;
			check_bit("hblank at rdy release", hblank, 1'b1);
		end

		// VSYNC and VBLANK bits
		write_reg(COLUP0, 8'hfe);
		write_reg(VSYNC, 8'h02);
		step_clk();
		@(negedge clk);
		check_bit("vsync set", vsync, 1'b1);
		wait_hblank_low();
		if (timed_out) return;
		write_reg(VBLANK, 8'h02);
		step_clk();
		@(negedge clk);
		check_bit("vblank set", vblank, 1'b1);
		check_color("col_lum in vblank", {col, lum}, '0);
		wait_line_starts(1);
		if (timed_out) return;
		write_reg(VSYNC, 8'hfd);       // Every bit but D1
		write_reg(VBLANK, 8'h00);
		step_clk();
		@(negedge clk);
		check_bit("vsync cleared", vsync, 1'b0);
		check_bit("vblank cleared", vblank, 1'b0);
		wait_line_starts(1);
	endtask

	initial begin
		reset      = 1'b1;
		ce         = 1'b0;
		wr         = 1'b0;
		addr       = VSYNC;
		d_in       = '0;
		lfsr_state = 16'd98;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		run_tests();
		step_clk();
		step_clk();
		if (!timed_out && lines_checked < 8) begin
			errors++;
			$display("Only %0d full lines were measured", lines_checked);
		end
		$display("Checks: %0d  errors: %0d  lines measured: %0d", checks, errors, lines_checked);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+tb
src/tia_reg_pkg.sv
src/tia_video_pkg.sv
src/tia_regs.sv
src/horiz_gen.sv
src/playfield.sv
src/color_output.sv
src/tia_top.sv
tb/tb_tia.sv
